// ==== all.f ====
rtl/fc_layer_pkg.sv
rtl/input_buffer.sv
rtl/coef_rom.sv
rtl/mac_lane.sv
rtl/output_serializer.sv
rtl/fc_sequencer.sv
rtl/fc_layer.sv
verif/fc_layer_assertions.sv
verif/tb_fc_layer.sv

// ==== biases.hex ====
// one signed 16-bit bias per line, by output index
0010
FFF0
0005
0020
FF00
0008
0000
0030

// ==== rtl/coef_rom.sv ====
`timescale 1ns/1ps

module coef_rom #(
   parameter int IN_LEN  = fc_layer_pkg::DEF_IN_LEN,
   parameter int OUT_LEN = fc_layer_pkg::DEF_OUT_LEN,
   parameter int LANES   = fc_layer_pkg::DEF_LANES,
   parameter int LANE_ID = 0,
   localparam int GROUPS = OUT_LEN / LANES,
   localparam int IDX_W  = (IN_LEN > 1) ? $clog2(IN_LEN) : 1,
   localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1
) (
   input  logic                clk,
   input  logic [GRP_W-1:0]    group,
   input  logic [IDX_W-1:0]    index,
   output fc_layer_pkg::word_t weight,
   output fc_layer_pkg::word_t bias
);
   import fc_layer_pkg::*;

   localparam int OUT_W  = (OUT_LEN > 1) ? $clog2(OUT_LEN) : 1;
   localparam int ADDR_W = (OUT_LEN * IN_LEN > 1) ? $clog2(OUT_LEN * IN_LEN) : 1;

   word_t weights [OUT_LEN * IN_LEN];
   word_t biases  [OUT_LEN];

   logic [OUT_W-1:0]  out_idx;
   logic [ADDR_W-1:0] w_addr;

   initial begin
      $readmemh("weights.hex", weights);
      $readmemh("biases.hex", biases);
   end

   // weights are stored row by row, one row per output
   assign out_idx = OUT_W'(group * LANES + LANE_ID);
   assign w_addr  = ADDR_W'(out_idx * IN_LEN + index);

   always_ff @(posedge clk) begin
      weight <= weights[w_addr];
      bias   <= biases[out_idx];
   end

endmodule

// ==== rtl/fc_layer.sv ====
`timescale 1ns/1ps

module fc_layer #(
   parameter int IN_LEN  = fc_layer_pkg::DEF_IN_LEN,
   parameter int OUT_LEN = fc_layer_pkg::DEF_OUT_LEN,
   parameter int LANES   = fc_layer_pkg::DEF_LANES
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                s_valid,
   output logic                s_ready,
   input  fc_layer_pkg::word_t data_in,
   output logic                m_valid,
   input  logic                m_ready,
   output fc_layer_pkg::word_t data_out
);
   import fc_layer_pkg::*;

   localparam int GROUPS = OUT_LEN / LANES;
   localparam int IDX_W  = (IN_LEN > 1) ? $clog2(IN_LEN) : 1;
   localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1;

   logic              buf_wr;
   logic [IDX_W-1:0]  buf_index;
   logic [GRP_W-1:0]  group;
   logic              acc_start;
   logic              acc_step;
   logic              acc_last;
   logic              serializer_empty;
   logic              load;
   word_t             x;
   word_t [LANES-1:0] lane_results;

   fc_sequencer #(
      .IN_LEN (IN_LEN),
      .OUT_LEN(OUT_LEN),
      .LANES  (LANES)
   ) u_seq (
      .clk             (clk),
      .reset           (reset),
      .s_valid         (s_valid),
      .s_ready         (s_ready),
      .buf_wr          (buf_wr),
      .buf_index       (buf_index),
      .group           (group),
      .acc_start       (acc_start),
      .acc_step        (acc_step),
      .acc_last        (acc_last),
      .serializer_empty(serializer_empty),
      .load            (load)
   );

   input_buffer #(
      .IN_LEN(IN_LEN)
   ) u_buf (
      .clk     (clk),
      .wr      (buf_wr),
      .index   (buf_index),
      .data_in (data_in),
      .data_out(x)
   );

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      word_t weight;
      word_t bias;

      coef_rom #(
         .IN_LEN (IN_LEN),
         .OUT_LEN(OUT_LEN),
         .LANES  (LANES),
         .LANE_ID(l)
      ) u_rom (
         .clk   (clk),
         .group (group),
         .index (buf_index),
         .weight(weight),
         .bias  (bias)
      );

      mac_lane u_lane (
         .clk         (clk),
         .acc_start   (acc_start),
         .acc_step    (acc_step),
         .acc_last    (acc_last),
         .x           (x),
         .weight      (weight),
         .bias        (bias),
         .load        (load),
         .result      (lane_results[l]),
         .result_valid()
      );
   end

   output_serializer #(
      .LANES(LANES)
   ) u_ser (
      .clk     (clk),
      .reset   (reset),
      .load    (load),
      .results (lane_results),
      .empty   (serializer_empty),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .data_out(data_out)
   );

endmodule

// ==== rtl/fc_layer_pkg.sv ====
package fc_layer_pkg;

   // every data, weight and bias word
   localparam int DATA_WIDTH = 16;

   typedef logic signed [DATA_WIDTH-1:0] word_t;

   // default layer shape, the top level passes these down
   localparam int DEF_IN_LEN  = 8;
   localparam int DEF_OUT_LEN = 8;
   localparam int DEF_LANES   = 4;

endpackage

// ==== rtl/fc_sequencer.sv ====
`timescale 1ns/1ps

module fc_sequencer #(
   parameter int IN_LEN  = fc_layer_pkg::DEF_IN_LEN,
   parameter int OUT_LEN = fc_layer_pkg::DEF_OUT_LEN,
   parameter int LANES   = fc_layer_pkg::DEF_LANES,
   localparam int GROUPS = OUT_LEN / LANES,
   localparam int IDX_W  = (IN_LEN > 1) ? $clog2(IN_LEN) : 1,
   localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             s_valid,
   output logic             s_ready,
   output logic             buf_wr,
   output logic [IDX_W-1:0] buf_index,
   output logic [GRP_W-1:0] group,
   output logic             acc_start,
   output logic             acc_step,
   output logic             acc_last,
   input  logic             serializer_empty,
   output logic             load
);

   localparam logic [2:0] S_IDLE      = 3'd0;
   localparam logic [2:0] S_CAPTURE   = 3'd1;
   localparam logic [2:0] S_COMPUTE   = 3'd2;
   localparam logic [2:0] S_WAIT_LOAD = 3'd3;
   localparam logic [2:0] S_FINAL     = 3'd4;

   localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(IN_LEN - 1);
   localparam logic [GRP_W-1:0] LAST_GROUP = GRP_W'(GROUPS - 1);

   logic [2:0] state;
   logic       issue;
   // mirrors the lanes' result_valid
   logic       res_ready;

   assign s_ready = (state == S_IDLE) || (state == S_CAPTURE);
   assign buf_wr  = s_valid && s_ready;
   assign issue   = (state == S_COMPUTE);

   // reset also flushes the lane result flags, which have no reset of their own
   assign load = reset || (res_ready && serializer_empty);

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= S_IDLE;
         buf_index <= '0;
         group     <= '0;
      end else begin
         case (state)
            S_IDLE, S_CAPTURE: begin
               if (buf_wr) begin
                  if (buf_index == LAST_INDEX) begin
                     buf_index <= '0;
                     state     <= S_COMPUTE;
                  end else begin
                     buf_index <= buf_index + 1'b1;
                     state     <= S_CAPTURE;
                  end
               end
            end

            // one buffer and coefficient read per cycle
            S_COMPUTE: begin
               if (buf_index == LAST_INDEX) begin
                  buf_index <= '0;
                  if (group == LAST_GROUP) begin
                     state <= S_FINAL;
                  end else begin
                     state <= S_WAIT_LOAD;
                  end
               end else begin
                  buf_index <= buf_index + 1'b1;
               end
            end

            // next group starts right after the hand-off
            S_WAIT_LOAD: begin
               if (load) begin
                  group <= group + 1'b1;
                  state <= S_COMPUTE;
               end
            end

            // a new vector may come in while this group streams out
            S_FINAL: begin
               if (load) begin
                  group <= '0;
                  state <= S_IDLE;
               end
            end

            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // enables trail the read index by the one-cycle memory latency
   always_ff @(posedge clk) begin
      if (reset) begin
         acc_step  <= 1'b0;
         acc_start <= 1'b0;
         acc_last  <= 1'b0;
         res_ready <= 1'b0;
      end else begin
         acc_step  <= issue;
         acc_start <= issue && (buf_index == '0);
         acc_last  <= issue && (buf_index == LAST_INDEX);
         if (acc_last) begin
            res_ready <= 1'b1;
         end else if (load) begin
            res_ready <= 1'b0;
         end
      end
   end

endmodule

// ==== rtl/input_buffer.sv ====
`timescale 1ns/1ps

module input_buffer #(
   parameter int IN_LEN = fc_layer_pkg::DEF_IN_LEN,
   localparam int IDX_W = (IN_LEN > 1) ? $clog2(IN_LEN) : 1
) (
   input  logic                clk,
   input  logic                wr,
   input  logic [IDX_W-1:0]    index,
   input  fc_layer_pkg::word_t data_in,
   output fc_layer_pkg::word_t data_out
);
   import fc_layer_pkg::*;

   word_t mem [IN_LEN];

   // read returns the old word if written in the same cycle
   always_ff @(posedge clk) begin
      data_out <= mem[index];
      if (wr) begin
         mem[index] <= data_in;
      end
   end

endmodule

// ==== rtl/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
   input  logic                clk,
   input  logic                acc_start,
   input  logic                acc_step,
   input  logic                acc_last,
   input  fc_layer_pkg::word_t x,
   input  fc_layer_pkg::word_t weight,
   input  fc_layer_pkg::word_t bias,
   input  logic                load,
   output fc_layer_pkg::word_t result,
   output logic                result_valid
);
   import fc_layer_pkg::*;

   word_t acc;
   word_t prod;
   word_t base;
   word_t sum;

   // 16-bit product and sum, both wrap
   assign prod = x * weight;
   assign base = acc_start ? bias : acc;
   assign sum  = base + prod;

   always_ff @(posedge clk) begin
      if (acc_step) begin
         acc <= sum;
      end
   end

   // rectify on the last beat; result holds until the serializer takes it
   always_ff @(posedge clk) begin
      if (acc_step && acc_last) begin
         if (sum[DATA_WIDTH-1]) begin
            result <= '0;
         end else begin
            result <= sum;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc_step && acc_last) begin
         result_valid <= 1'b1;
      end else if (load) begin
         result_valid <= 1'b0;
      end
   end

endmodule

// ==== rtl/output_serializer.sv ====
`timescale 1ns/1ps

module output_serializer #(
   parameter int LANES = fc_layer_pkg::DEF_LANES,
   localparam int SEL_W = (LANES > 1) ? $clog2(LANES) : 1
) (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             load,
   input  fc_layer_pkg::word_t [LANES-1:0]  results,
   output logic                             empty,
   output logic                             m_valid,
   input  logic                             m_ready,
   output fc_layer_pkg::word_t              data_out
);
   import fc_layer_pkg::*;

   localparam logic [SEL_W-1:0] LAST_SEL = SEL_W'(LANES - 1);

   word_t [LANES-1:0] held;
   logic [SEL_W-1:0]  sel;
   logic              fire;
   logic              take;

   assign fire     = m_valid && m_ready;
   // free once the final word of the group leaves
   assign empty    = !m_valid || (fire && (sel == LAST_SEL));
   assign take     = load && empty;
   assign data_out = held[sel];

   always_ff @(posedge clk) begin
      if (reset) begin
         m_valid <= 1'b0;
         sel     <= '0;
      end else if (take) begin
         m_valid <= 1'b1;
         sel     <= '0;
      end else if (fire) begin
         if (sel == LAST_SEL) begin
            m_valid <= 1'b0;
         end else begin
            sel <= sel + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         held <= results;
      end
   end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the fc_layer testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_fc_layer -Mdir obj_dir -o sim_fc_layer -f all.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_fc_layer
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

echo "simulation finished"
exit 0

// ==== verif/fc_layer_assertions.sv ====
`timescale 1ns/1ps

module fc_layer_assertions (
   input logic                clk,
   input logic                reset,
   input logic                m_valid,
   input logic                m_ready,
   input fc_layer_pkg::word_t data_out
);
   import fc_layer_pkg::*;

   // output stream is idle right after reset
   a_idle_after_reset: assert property (@(posedge clk) reset |=> !m_valid)
      else $error("m_valid high in the cycle after reset");

   // a stalled word must not change or vanish
   a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      (m_valid && !m_ready) |=> (m_valid && $stable(data_out)))
      else $error("output word changed while stalled");

   // rectified results are never negative
   a_non_negative: assert property (@(posedge clk) disable iff (reset)
      m_valid |-> !data_out[DATA_WIDTH-1])
      else $error("negative word on data_out");

endmodule

bind fc_layer fc_layer_assertions u_assertions (
   .clk     (clk),
   .reset   (reset),
   .m_valid (m_valid),
   .m_ready (m_ready),
   .data_out(data_out)
);

// ==== verif/tb_fc_layer.sv ====
`timescale 1ns/1ps

module tb_fc_layer;
   import fc_layer_pkg::*;

   localparam int IN_LEN    = DEF_IN_LEN;
   localparam int OUT_LEN   = DEF_OUT_LEN;
   localparam int LANES     = DEF_LANES;
   localparam int GROUPS    = OUT_LEN / LANES;
   localparam int ROWS      = 6;
   localparam int MAX_STALL = 8;
   localparam int LIMIT     = ROWS * 2 * (IN_LEN + GROUPS * (IN_LEN + 4) + OUT_LEN * MAX_STALL);

   logic  clk;
   logic  reset;
   logic  s_valid;
   logic  s_ready;
   word_t data_in;
   logic  m_valid;
   logic  m_ready;
   word_t data_out;

   logic [LANES-1:0] lane_valid;

   // per row the input vector, a gap mask and an m_ready stall percent
   // gap bit i inserts an idle cycle before word i
   word_t vec_tab [ROWS][IN_LEN] = '{
      '{16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005, 16'h0006, 16'h0007, 16'h0008},
      '{16'h4000, 16'h7FFF, 16'hFED4, 16'h2000, 16'h8000, 16'h0064, 16'h1234, 16'hEC78},
      '{16'h4000, 16'h7FFF, 16'hFED4, 16'h2000, 16'h8000, 16'h0064, 16'h1234, 16'hEC78},
      '{16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005, 16'h0006, 16'h0007, 16'h0008},
      '{16'h000A, 16'hFFFD, 16'h0007, 16'h0000, 16'h0014, 16'hFFF1, 16'h0004, 16'h0009},
      '{16'h0FFF, 16'hFFFF, 16'h7000, 16'h0003, 16'hF830, 16'h0800, 16'hFFF9, 16'h3000}
   };
   logic [IN_LEN-1:0] gap_tab [ROWS] = '{8'h00, 8'h00, 8'h00, 8'hA6, 8'h00, 8'h11};
   int stall_tab [ROWS] = '{0, 0, 40, 0, 25, 60};

   word_t       weights_ref [OUT_LEN * IN_LEN];
   word_t       biases_ref [OUT_LEN];
   word_t       exp_tab [ROWS][OUT_LEN];
   logic [31:0] lcg_state = 32'h9f1897cf;
   int          cycles = 0;

   fc_layer #(
      .IN_LEN (IN_LEN),
      .OUT_LEN(OUT_LEN),
      .LANES  (LANES)
   ) dut (
      .clk     (clk),
      .reset   (reset),
      .s_valid (s_valid),
      .s_ready (s_ready),
      .data_in (data_in),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .data_out(data_out)
   );

   // lane result flags seen through the hierarchy
   for (genvar l = 0; l < LANES; l++) begin : g_probe
      assign lane_valid[l] = dut.g_lane[l].u_lane.result_valid;
   end

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: outputs did not all arrive within %0d cycles", LIMIT);
         $display("Regression failed");
         $fatal(1, "run stopped by cycle limit");
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // bias plus wrapped products with negatives clamped to zero
   function automatic word_t model_output(input int r, input int o);
      word_t acc;
      acc = biases_ref[o];
      for (int i = 0; i < IN_LEN; i++) begin
         acc = acc + vec_tab[r][i] * weights_ref[o * IN_LEN + i];
      end
      if (acc < 0) begin
         acc = '0;
      end
      return acc;
   endfunction

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
         $display("Regression failed");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
         $display("Regression failed");
         $fatal(1, "handshake mismatch");
      end
   endtask

   // holds the word until a cycle where s_ready was seen high
   task automatic send_word(input word_t w);
      logic hit;
      s_valid = 1'b1;
      data_in = w;
      do begin
         @(negedge clk);
         hit = s_ready;
         @(posedge clk);
         #2;
      end while (!hit);
      s_valid = 1'b0;
   endtask

   // every vector starts as soon as the layer accepts input again
   task automatic send_all();
      for (int r = 0; r < ROWS; r++) begin
         for (int i = 0; i < IN_LEN; i++) begin
            if (gap_tab[r][i]) begin
               s_valid = 1'b0;
               @(posedge clk);
               #2;
            end
            send_word(vec_tab[r][i]);
         end
      end
   endtask

   task automatic receive_all();
      int n;
      int r;
      int stall_run;
      n = 0;
      stall_run = 0;
      while (n < ROWS * OUT_LEN) begin
         r = n / OUT_LEN;
         @(posedge clk);
         #2;
         lcg_state = lcg_next(lcg_state);
         if (stall_run >= MAX_STALL || ((lcg_state >> 16) % 100) >= stall_tab[r]) begin
            m_ready = 1'b1;
            stall_run = 0;
         end else begin
            m_ready = 1'b0;
            stall_run++;
         end
         @(negedge clk);
         if (m_valid && m_ready) begin
            check_word($sformatf("data_out row %0d index %0d", r, n % OUT_LEN),
                       exp_tab[r][n % OUT_LEN], data_out);
            n++;
         end
      end
   endtask

   initial begin
      reset   = 1'b1;
      s_valid = 1'b0;
      data_in = '0;
      m_ready = 1'b0;
      $readmemh("weights.hex", weights_ref);
      $readmemh("biases.hex", biases_ref);
      for (int r = 0; r < ROWS; r++) begin
         for (int o = 0; o < OUT_LEN; o++) begin
            exp_tab[r][o] = model_output(r, o);
         end
      end
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      check_bit("m_valid", 1'b0, m_valid);
      check_bit("s_ready", 1'b1, s_ready);
      for (int l = 0; l < LANES; l++) begin
         check_bit($sformatf("result_valid lane %0d", l), 1'b0, lane_valid[l]);
      end
      @(posedge clk);
      #2;
      fork
         send_all();
         receive_all();
      join
      // nothing extra may follow the last expected word
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_bit("m_valid", 1'b0, m_valid);
      check_bit("s_ready", 1'b1, s_ready);
      $display("Regression passed");
      $finish;
   end

endmodule

// ==== weights.hex ====
// one signed 16-bit weight per line
// row by output index, then by input index within the row
0001
0002
0003
0004
FFFF
0002
0001
0003
FFFE
0001
0004
FFFD
0002
0001
FFFF
0002
0003
FFFF
0002
0001
0005
FFFC
0002
0001
0002
0002
FFFE
0003
0001
0004
FFFD
0002
FFFF
0003
0001
0002
FFFE
0003
0004
0001
0004
FFFE
0003
0001
0002
FFFF
0003
FFFE
0001
0004
FFFD
0002
0003
0001
0002
0005
FFFD
0001
0002
0006
FFFF
0002
0001
0003
